// File: logic/dbg_pkg.sv
// Shared widths, bit positions and types for the CPU debug port
// Every RTL file refers to these by scoped name
`default_nettype none

package dbg_pkg;

	////////////////////
	// Bus widths
	////////////////////
	localparam int DBG_DW = 32;
	localparam int DBG_AW = 8;
	// Byte address bits dropped to form a word address
	localparam int DBG_LSB = 2;
	localparam int DBG_WORD_AW = DBG_AW - DBG_LSB;
	// Word address bit that selects the control/status word
	localparam int CTRL_SEL_BIT = 5;
	// CPU register index
	localparam int REG_W = 5;

	////////////////////
	// Command bits
	////////////////////
	// Reset sits in strobe byte 0, the rest in byte 1
	localparam int RESET_BIT = 6;
	localparam int STEP_BIT = 8;
	localparam int HALT_BIT = 10;
	localparam int CLEAR_CACHE_BIT = 11;

	// Status word bits
	localparam int ST_IRQ_BIT = 7;
	localparam int ST_RUN_BIT = 9;
	localparam int ST_CC_LSB = 12;
	localparam int ST_BREAK_BIT = 15;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef logic [DBG_WORD_AW-1:0] word_addr_t;
	typedef logic [DBG_DW-1:0] dbg_word_t;
	typedef logic [2:0] cc_t;

	// Write data beat with its byte strobes
	typedef struct packed {
		dbg_word_t data;
		logic [DBG_DW/8-1:0] strb;
	} wdata_t;

endpackage

`default_nettype wire

// File: logic/dbg_skid.sv
// Skid buffer for one AXI-lite channel of the debug port
// Empty: payload passes straight through with no latency
// On a downstream stall one beat is held and o_ready drops
`timescale 1ns/1ns
`default_nettype none

module dbg_skid #(
	parameter type T_PAYLOAD = logic [7:0]
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Upstream side
	input wire i_valid,
	output logic o_ready,
	input wire T_PAYLOAD i_data,
	// Downstream side
	output logic o_valid,
	input wire i_ready,
	output T_PAYLOAD o_data
);

	logic r_valid;
	T_PAYLOAD r_data;

	// Held beat flag
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_ready)
			r_valid <= 1'b0;
		else if (i_valid && o_ready)
			r_valid <= 1'b1;
	end

	// Capture while empty, freeze while holding
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!r_valid)
			r_data <= i_data;
	end

	assign o_ready = !r_valid;
	assign o_valid = i_valid || r_valid;
	assign o_data = r_valid ? r_data : i_data;

	// A stalled beat must come back unchanged on the next cycle
	a_held_beat_stable: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN)
		(o_valid && !i_ready) |=> (o_valid && (o_data == $past(o_data))))
		else $error("skid buffer lost or changed a held beat");

endmodule

`default_nettype wire

// File: logic/dbg_write_path.sv
// Write side of the AXI-lite debug slave
// Joins AW and W, then routes each write either to a core register
// or, with the control select bit set, to the run controller
// B is raised one cycle after a write is accepted
`timescale 1ns/1ns
`default_nettype none

module dbg_write_path (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// AXI-lite write channels
	input wire i_awvalid,
	output logic o_awready,
	input wire [dbg_pkg::DBG_AW-1:0] i_awaddr,
	input wire i_wvalid,
	output logic o_wready,
	input wire dbg_pkg::dbg_word_t i_wdata,
	input wire [3:0] i_wstrb,
	output logic o_bvalid,
	input wire i_bready,
	output logic [1:0] o_bresp,
	// Core register write port
	output logic o_dbg_we,
	output logic [dbg_pkg::REG_W-1:0] o_dbg_wreg,
	output dbg_pkg::dbg_word_t o_dbg_wdata,
	input wire i_dbg_stall,
	// To the run controller
	output logic o_cmd_write,
	output dbg_pkg::dbg_word_t o_cmd_data,
	output logic [3:0] o_cmd_strb,
	output logic o_reg_write_accept
);

	logic aw_valid, w_valid;
	dbg_pkg::word_addr_t aw_addr;
	dbg_pkg::wdata_t w_in, w_beat;
	logic write_ready, reg_sel, reg_write, dbg_write_stall;

	////////////////////
	// Channel buffers
	////////////////////
	dbg_skid #(
		.T_PAYLOAD(dbg_pkg::word_addr_t)
	) u_aw_skid (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_awvalid),
		.o_ready(o_awready),
		.i_data(i_awaddr[dbg_pkg::DBG_AW-1:dbg_pkg::DBG_LSB]),
		.o_valid(aw_valid),
		.i_ready(write_ready),
		.o_data(aw_addr)
	);

	assign w_in = '{data: i_wdata, strb: i_wstrb};

	dbg_skid #(
		.T_PAYLOAD(dbg_pkg::wdata_t)
	) u_w_skid (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_wvalid),
		.o_ready(o_wready),
		.i_data(w_in),
		.o_valid(w_valid),
		.i_ready(write_ready),
		.o_data(w_beat)
	);

	// Words 0..31 are core registers
	assign reg_sel = !aw_addr[dbg_pkg::CTRL_SEL_BIT];
	// Zero strobes: acknowledge only
	assign reg_write = reg_sel && (|w_beat.strb);
	// Pending register write still blocked by the core
	assign dbg_write_stall = o_dbg_we && i_dbg_stall;

	// Accept when both halves are here and B has room
	assign write_ready = aw_valid && w_valid
		&& (!o_bvalid || i_bready)
		&& (!reg_write || !dbg_write_stall);

	////////////////////
	// Core register write
	////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_dbg_we <= 1'b0;
		else if (!dbg_write_stall)
			o_dbg_we <= write_ready && reg_write;
	end

	// Index and data hold with the strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!dbg_write_stall)
		begin
			o_dbg_wreg <= aw_addr[dbg_pkg::REG_W-1:0];
			o_dbg_wdata <= w_beat.data;
		end
	end

	// Command strobe is combinational on the accept cycle
	assign o_cmd_write = write_ready && !reg_sel;
	assign o_cmd_data = w_beat.data;
	assign o_cmd_strb = w_beat.strb;
	assign o_reg_write_accept = write_ready && reg_write;

	// Write response
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (write_ready)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	assign o_bresp = dbg_pkg::RESP_OKAY;

	a_bvalid_held: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN)
		(o_bvalid && !i_bready) |=> o_bvalid)
		else $error("BVALID dropped without BREADY");

endmodule

`default_nettype wire

// File: logic/dbg_read_path.sv
// Read side of the AXI-lite debug slave
// Status word reads answer one cycle after accept
// Core register reads wait a cycle for the core, answering after two
`timescale 1ns/1ns
`default_nettype none

module dbg_read_path (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// AXI-lite read channels
	input wire i_arvalid,
	output logic o_arready,
	input wire [dbg_pkg::DBG_AW-1:0] i_araddr,
	output logic o_rvalid,
	input wire i_rready,
	output dbg_pkg::dbg_word_t o_rdata,
	output logic [1:0] o_rresp,
	// Core register read port
	output logic [dbg_pkg::REG_W-1:0] o_dbg_rreg,
	input wire dbg_pkg::dbg_word_t i_dbg_rdata,
	// From the run controller
	input wire dbg_pkg::dbg_word_t i_status
);

	logic ar_valid, read_ready, read_pending, ctrl_sel;
	dbg_pkg::word_addr_t ar_addr;

	dbg_skid #(
		.T_PAYLOAD(dbg_pkg::word_addr_t)
	) u_ar_skid (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_arvalid),
		.o_ready(o_arready),
		.i_data(i_araddr[dbg_pkg::DBG_AW-1:dbg_pkg::DBG_LSB]),
		.o_valid(ar_valid),
		.i_ready(read_ready),
		.o_data(ar_addr)
	);

	// Any word with the select bit set is the status word
	assign ctrl_sel = ar_addr[dbg_pkg::CTRL_SEL_BIT];

	// One core read outstanding at most, R must have room
	assign read_ready = ar_valid && !read_pending && (!o_rvalid || i_rready);

	// Core sees the index on the accept cycle
	assign o_dbg_rreg = ar_addr[dbg_pkg::REG_W-1:0];

	////////////////////
	// Read sequencing
	////////////////////
	// Core data comes back the cycle after accept
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			read_pending <= 1'b0;
		else
			read_pending <= read_ready && !ctrl_sel;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (!o_rvalid || i_rready)
			o_rvalid <= (read_ready && ctrl_sel) || read_pending;
	end

	// Data only moves when R is free or being taken
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_rvalid || i_rready)
		begin
			if (read_pending)
				o_rdata <= i_dbg_rdata;
			else
				o_rdata <= i_status;
		end
	end

	assign o_rresp = dbg_pkg::RESP_OKAY;

	a_rdata_stable: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN)
		(o_rvalid && !i_rready) |=> (o_rvalid && $stable(o_rdata)))
		else $error("RDATA changed while RVALID waited");

endmodule

`default_nettype wire

// File: logic/cpu_run_control.sv
// Run control for the CPU core
// Holds the core in reset after power-up or an external reset, then
// turns debug command writes into reset, halt, step and clear-cache
// Also builds the status word returned on status reads
`timescale 1ns/1ns
`default_nettype none

module cpu_run_control #(
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED = 1'b0
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire i_cpu_reset,
	input wire i_interrupt,
	// From the write path
	input wire i_cmd_write,
	input wire dbg_pkg::dbg_word_t i_cmd_data,
	input wire [3:0] i_cmd_strb,
	input wire i_reg_write_accept,
	// Core state
	input wire i_dbg_stall,
	input wire i_break,
	input wire dbg_pkg::cc_t i_cc,
	// To the core and the read path
	output logic o_cpu_reset,
	output logic o_halt,
	output logic o_clear_cache,
	output dbg_pkg::dbg_word_t o_status
);

	localparam int CW = $clog2(RESET_DURATION);

	logic [CW-1:0] reset_counter;
	logic reset_hold;
	logic cmd_reset, cmd_halt, cmd_step, cmd_clear_cache;
	logic hi_write, step_req, halt_req, cc_req;

	// Byte 1 carries step, halt and clear-cache
	assign hi_write = i_cmd_write && i_cmd_strb[1];
	assign step_req = hi_write && i_cmd_data[dbg_pkg::STEP_BIT];
	assign halt_req = hi_write && i_cmd_data[dbg_pkg::HALT_BIT];
	assign cc_req = hi_write && i_cmd_data[dbg_pkg::CLEAR_CACHE_BIT];

	////////////////////
	// Reset hold
	////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			reset_counter <= CW'(RESET_DURATION - 1);
		else if (reset_counter != 0)
			reset_counter <= reset_counter - 1'b1;
	end

	assign reset_hold = (reset_counter != 0);

	// Held during count, else a one-cycle pulse
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			cmd_reset <= 1'b1;
		else if (reset_hold)
			cmd_reset <= 1'b1;
		else if (i_break && !START_HALTED)
			cmd_reset <= 1'b1;
		else
			cmd_reset <= i_cmd_write && i_cmd_strb[0]
				&& i_cmd_data[dbg_pkg::RESET_BIT];
	end

	////////////////////
	// Halt
	////////////////////
	// Later reasons win over the release
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			cmd_halt <= START_HALTED;
		else if (cmd_reset && START_HALTED)
			cmd_halt <= START_HALTED;
		else
		begin
			// Release, or release for a single step
			if (!i_dbg_stall && hi_write
				&& (!i_cmd_data[dbg_pkg::HALT_BIT] || step_req))
				cmd_halt <= 1'b0;
			// Break halts when not resetting on it
			if (i_break && START_HALTED)
				cmd_halt <= 1'b1;
			// Explicit request, unless stepping
			if (halt_req && !step_req)
				cmd_halt <= 1'b1;
			// Core registers only change while halted
			if (i_reg_write_accept)
				cmd_halt <= 1'b1;
			// Back to halt once the stepped core is idle
			if (cmd_step && !i_dbg_stall)
				cmd_halt <= 1'b1;
			// Stay halted through a cache clear
			if (cmd_clear_cache)
				cmd_halt <= 1'b1;
			if (cc_req)
				cmd_halt <= 1'b1;
		end
	end

	// Step lasts until the core moves
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			cmd_step <= 1'b0;
		else if (step_req)
			cmd_step <= 1'b1;
		else if (!i_dbg_stall)
			cmd_step <= 1'b0;
	end

	// Clear-cache only with halt also set in the write
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || cmd_reset)
			cmd_clear_cache <= 1'b0;
		else if (cc_req && i_cmd_data[dbg_pkg::HALT_BIT])
			cmd_clear_cache <= 1'b1;
		else if (cmd_halt && !i_dbg_stall)
			cmd_clear_cache <= 1'b0;
	end

	// Status word, unlisted bits read 0
	always_comb
	begin
		o_status = '0;
		o_status[dbg_pkg::RESET_BIT] = cmd_reset;
		o_status[dbg_pkg::ST_IRQ_BIT] = i_interrupt;
		o_status[dbg_pkg::ST_RUN_BIT] = !i_dbg_stall;
		o_status[dbg_pkg::HALT_BIT] = cmd_halt;
		o_status[dbg_pkg::ST_CC_LSB +: $bits(dbg_pkg::cc_t)] = i_cc;
		o_status[dbg_pkg::ST_BREAK_BIT] = i_break;
	end

	assign o_cpu_reset = cmd_reset;
	assign o_halt = cmd_halt;
	assign o_clear_cache = cmd_clear_cache;

	// Step and cache clear hand the core back halted
	a_step_rehalts: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN || i_cpu_reset)
		(cmd_step && !i_dbg_stall) |=> cmd_halt)
		else $error("halt not restored after step");

	a_clear_cache_rehalts: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN || i_cpu_reset)
		(cmd_clear_cache && !i_dbg_stall) |=> cmd_halt)
		else $error("halt not held after cache clear");

endmodule

`default_nettype wire

// File: logic/cpu_debug_port.sv
// Debug and run-control port of the CPU, top level
// Connects the AXI-lite debug slave to the core's debug pins
// Write path, read path and run controller are joined here
`timescale 1ns/1ns
`default_nettype none

module cpu_debug_port #(
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED = 1'b0
) (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire i_cpu_reset,
	input wire i_interrupt,
	// AXI-lite debug slave
	input wire i_s_dbg_awvalid,
	output logic o_s_dbg_awready,
	input wire [dbg_pkg::DBG_AW-1:0] i_s_dbg_awaddr,
	input wire [2:0] i_s_dbg_awprot,
	input wire i_s_dbg_wvalid,
	output logic o_s_dbg_wready,
	input wire dbg_pkg::dbg_word_t i_s_dbg_wdata,
	input wire [3:0] i_s_dbg_wstrb,
	output logic o_s_dbg_bvalid,
	input wire i_s_dbg_bready,
	output logic [1:0] o_s_dbg_bresp,
	input wire i_s_dbg_arvalid,
	output logic o_s_dbg_arready,
	input wire [dbg_pkg::DBG_AW-1:0] i_s_dbg_araddr,
	input wire [2:0] i_s_dbg_arprot,
	output logic o_s_dbg_rvalid,
	input wire i_s_dbg_rready,
	output dbg_pkg::dbg_word_t o_s_dbg_rdata,
	output logic [1:0] o_s_dbg_rresp,
	// Core debug pins
	output logic o_dbg_we,
	output logic [dbg_pkg::REG_W-1:0] o_dbg_wreg,
	output dbg_pkg::dbg_word_t o_dbg_wdata,
	output logic [dbg_pkg::REG_W-1:0] o_dbg_rreg,
	input wire dbg_pkg::dbg_word_t i_dbg_rdata,
	input wire i_dbg_stall,
	input wire i_break,
	input wire dbg_pkg::cc_t i_cc,
	output logic o_cpu_reset,
	output logic o_halt,
	output logic o_clear_cache
);

	logic cmd_write, reg_write_accept;
	dbg_pkg::dbg_word_t cmd_data, status;
	logic [3:0] cmd_strb;

	////////////////////
	// Bus side
	////////////////////
	dbg_write_path u_write_path (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awvalid(i_s_dbg_awvalid), .o_awready(o_s_dbg_awready),
		.i_awaddr(i_s_dbg_awaddr),
		.i_wvalid(i_s_dbg_wvalid), .o_wready(o_s_dbg_wready),
		.i_wdata(i_s_dbg_wdata), .i_wstrb(i_s_dbg_wstrb),
		.o_bvalid(o_s_dbg_bvalid), .i_bready(i_s_dbg_bready),
		.o_bresp(o_s_dbg_bresp),
		.o_dbg_we(o_dbg_we), .o_dbg_wreg(o_dbg_wreg),
		.o_dbg_wdata(o_dbg_wdata), .i_dbg_stall(i_dbg_stall),
		.o_cmd_write(cmd_write), .o_cmd_data(cmd_data),
		.o_cmd_strb(cmd_strb), .o_reg_write_accept(reg_write_accept)
	);

	dbg_read_path u_read_path (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_arvalid(i_s_dbg_arvalid), .o_arready(o_s_dbg_arready),
		.i_araddr(i_s_dbg_araddr),
		.o_rvalid(o_s_dbg_rvalid), .i_rready(i_s_dbg_rready),
		.o_rdata(o_s_dbg_rdata), .o_rresp(o_s_dbg_rresp),
		.o_dbg_rreg(o_dbg_rreg), .i_dbg_rdata(i_dbg_rdata),
		.i_status(status)
	);

	// Core control
	cpu_run_control #(
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(START_HALTED)
	) u_run_control (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cpu_reset(i_cpu_reset), .i_interrupt(i_interrupt),
		.i_cmd_write(cmd_write), .i_cmd_data(cmd_data),
		.i_cmd_strb(cmd_strb), .i_reg_write_accept(reg_write_accept),
		.i_dbg_stall(i_dbg_stall), .i_break(i_break), .i_cc(i_cc),
		.o_cpu_reset(o_cpu_reset), .o_halt(o_halt),
		.o_clear_cache(o_clear_cache), .o_status(status)
	);

	// PROT is accepted on AW and AR but carries no meaning here

endmodule

`default_nettype wire

// File: sim/tb_cpu_stub.sv
// Behavioural stand-in for the CPU core on the debug pins
// Register file, a stall counter loaded after each register write,
// and a registered break output raised on request from the testbench
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_stub (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire i_dbg_we,
	input wire [dbg_pkg::REG_W-1:0] i_dbg_wreg,
	input wire dbg_pkg::dbg_word_t i_dbg_wdata,
	input wire [dbg_pkg::REG_W-1:0] i_dbg_rreg,
	output dbg_pkg::dbg_word_t o_dbg_rdata,
	output logic o_dbg_stall,
	input wire i_halt,
	// Stall length loaded on each register write
	input wire [1:0] i_stall_len,
	input wire i_break_req,
	output logic o_break,
	output dbg_pkg::cc_t o_cc
);

	dbg_pkg::dbg_word_t regs [0:(1 << dbg_pkg::REG_W) - 1];
	logic [1:0] stall_cnt;
	logic halt_q;
	logic write_fire;

	// Core takes the write only when not stalled
	assign write_fire = i_dbg_we && !o_dbg_stall;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (write_fire)
			regs[i_dbg_wreg] <= i_dbg_wdata;
		o_dbg_rdata <= regs[i_dbg_rreg];
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			stall_cnt <= 2'd0;
			halt_q <= 1'b0;
			o_break <= 1'b0;
		end
		else
		begin
			halt_q <= i_halt;
			o_break <= i_break_req;
			if (write_fire)
				stall_cnt <= i_stall_len;
			else if (stall_cnt != 0)
				stall_cnt <= stall_cnt - 1'b1;
		end
	end

	// Busy while running or while a write settles
	assign o_dbg_stall = !halt_q || (stall_cnt != 0);
	assign o_cc = '0;

endmodule

`default_nettype wire

// File: sim/tb_cpu_debug_port.sv
// Testbench for the CPU debug port with a stub core
// Walks through reset hold, register access, halt, step, clear-cache,
// break and bus backpressure; concurrent assertions do the checking
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_debug_port;

	localparam int RESET_DURATION = 10;
	// Planned bus transactions, used for the timeout
	localparam int N_TRANS = 27;
	localparam int CYCLE_LIMIT = N_TRANS * 40 + 200;
	localparam logic [7:0] CTRL_ADDR = 8'h80;

	logic S_AXI_ACLK, S_AXI_ARESETN;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [7:0] awaddr, araddr;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp, stall_len;
	dbg_pkg::dbg_word_t wdata, rdata, dbg_wdata, dbg_rdata;
	logic dbg_we, dbg_stall, cpu_reset, halt, clear_cache, break_req, core_break;
	logic [dbg_pkg::REG_W-1:0] dbg_wreg, dbg_rreg;
	dbg_pkg::cc_t cc;

	// Expected values, armed by the stimulus around each transaction
	logic rd_chk, halt_chk, exp_halt, step_chk, cc_chk;
	dbg_pkg::dbg_word_t rd_mask, rd_exp;
	dbg_pkg::dbg_word_t shadow [0:31];
	int errors = 0;
	int writes_done = 0;
	int reads_done = 0;
	int cycle_count = 0;
	integer seed;

	cpu_debug_port #(
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(1'b0)
	) DUT (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cpu_reset(1'b0), .i_interrupt(1'b0),
		.i_s_dbg_awvalid(awvalid), .o_s_dbg_awready(awready),
		.i_s_dbg_awaddr(awaddr), .i_s_dbg_awprot(3'b000),
		.i_s_dbg_wvalid(wvalid), .o_s_dbg_wready(wready),
		.i_s_dbg_wdata(wdata), .i_s_dbg_wstrb(wstrb),
		.o_s_dbg_bvalid(bvalid), .i_s_dbg_bready(bready), .o_s_dbg_bresp(bresp),
		.i_s_dbg_arvalid(arvalid), .o_s_dbg_arready(arready),
		.i_s_dbg_araddr(araddr), .i_s_dbg_arprot(3'b000),
		.o_s_dbg_rvalid(rvalid), .i_s_dbg_rready(rready),
		.o_s_dbg_rdata(rdata), .o_s_dbg_rresp(rresp),
		.o_dbg_we(dbg_we), .o_dbg_wreg(dbg_wreg), .o_dbg_wdata(dbg_wdata),
		.o_dbg_rreg(dbg_rreg), .i_dbg_rdata(dbg_rdata), .i_dbg_stall(dbg_stall),
		.i_break(core_break), .i_cc(cc),
		.o_cpu_reset(cpu_reset), .o_halt(halt), .o_clear_cache(clear_cache)
	);

	tb_cpu_stub u_core (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_dbg_we(dbg_we), .i_dbg_wreg(dbg_wreg), .i_dbg_wdata(dbg_wdata),
		.i_dbg_rreg(dbg_rreg), .o_dbg_rdata(dbg_rdata), .o_dbg_stall(dbg_stall),
		.i_halt(halt), .i_stall_len(stall_len),
		.i_break_req(break_req), .o_break(core_break), .o_cc(cc)
	);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	task automatic report_error(input string msg);
		errors = errors + 1;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	////////////////////
	// Checks
	////////////////////
	a_reset_hold: assert property (@(posedge S_AXI_ACLK)
		$rose(S_AXI_ARESETN) |-> cpu_reset [*RESET_DURATION] ##1 !cpu_reset)
		else report_error("core reset hold has the wrong length");
	a_read_data: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(rvalid && rready && rd_chk) |-> ((rdata & rd_mask) == rd_exp))
		else report_error("read data differs from the expected value");
	a_halt_on_reg_write: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN) dbg_we |-> halt)
		else report_error("register write reached the core while running");
	a_halt_cmd: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		($rose(bvalid) && halt_chk) |-> (halt == exp_halt))
		else report_error("halt did not follow the halt command");
	a_step: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		($rose(bvalid) && step_chk) |-> !halt ##[1:4] halt)
		else report_error("step did not release and restore halt");
	a_clear_cache: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		($rose(bvalid) && cc_chk) |-> (clear_cache && halt) ##1 halt)
		else report_error("clear-cache not raised with halt held");
	a_break_reset: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$rose(core_break) |=> cpu_reset)
		else report_error("break did not reset the core");
	a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(bvalid && !bready) |=> bvalid)
		else report_error("BVALID dropped before BREADY");
	a_rdata_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(rvalid && !rready) |=> (rvalid && $stable(rdata)))
		else report_error("R channel changed before RREADY");
	a_resp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(bvalid || rvalid) |-> (bresp == dbg_pkg::RESP_OKAY && rresp == dbg_pkg::RESP_OKAY))
		else report_error("response code is not OKAY");

	////////////////////
	// Bus tasks
	////////////////////
	// Called and left on a falling edge; ready is sampled mid-cycle
	task automatic bus_write(input logic [7:0] addr, input dbg_pkg::dbg_word_t data,
		input logic [3:0] strb, input bit stretch);
		logic aw_pend, w_pend, aw_hs, w_hs;
		int hold;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		stall_len = 2'($random(seed));
		aw_pend = 1'b1;
		w_pend = 1'b1;
		while (aw_pend || w_pend)
		begin
			aw_hs = aw_pend && awready;
			w_hs = w_pend && wready;
			@(negedge S_AXI_ACLK);
			if (aw_hs)
			begin
				awvalid = 1'b0;
				aw_pend = 1'b0;
			end
			if (w_hs)
			begin
				wvalid = 1'b0;
				w_pend = 1'b0;
			end
		end
		// Optional BREADY low stretch
		hold = stretch ? ($random(seed) & 7) : 0;
		repeat (hold) @(negedge S_AXI_ACLK);
		bready = 1'b1;
		while (!bvalid) @(negedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		bready = 1'b0;
		writes_done = writes_done + 1;
	endtask

	task automatic bus_read(input logic [7:0] addr, input bit stretch);
		logic ar_hs;
		int hold;
		araddr = addr;
		arvalid = 1'b1;
		ar_hs = 1'b0;
		while (!ar_hs)
		begin
			ar_hs = arready;
			@(negedge S_AXI_ACLK);
		end
		arvalid = 1'b0;
		hold = stretch ? ($random(seed) & 7) : 0;
		repeat (hold) @(negedge S_AXI_ACLK);
		rready = 1'b1;
		while (!rvalid) @(negedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		rready = 1'b0;
		reads_done = reads_done + 1;
	endtask

	task automatic read_status_expect(input dbg_pkg::dbg_word_t mask,
		input dbg_pkg::dbg_word_t value);
		rd_mask = mask;
		rd_exp = value;
		rd_chk = 1'b1;
		bus_read(CTRL_ADDR, 1'b0);
		rd_chk = 1'b0;
	endtask

	task automatic write_reg(input logic [4:0] idx, input dbg_pkg::dbg_word_t data,
		input bit stretch);
		shadow[idx] = data;
		bus_write({1'b0, idx, 2'b00}, data, 4'hf, stretch);
	endtask

	// Readback only once the core has taken the pending write
	task automatic read_reg_expect(input logic [4:0] idx, input bit stretch);
		while (dbg_we) @(negedge S_AXI_ACLK);
		rd_mask = '1;
		rd_exp = shadow[idx];
		rd_chk = 1'b1;
		bus_read({1'b0, idx, 2'b00}, stretch);
		rd_chk = 1'b0;
	endtask

	// Byte 1 command; release and step need an idle core
	task automatic send_command(input dbg_pkg::dbg_word_t data, input bit wait_idle);
		if (wait_idle)
			while (dbg_stall) @(negedge S_AXI_ACLK);
		bus_write(CTRL_ADDR, data, 4'b0010, 1'b0);
	endtask

	////////////////////
	// Stimulus
	////////////////////
	initial
	begin
		logic [4:0] idx;
		dbg_pkg::dbg_word_t halt_word;
		seed = 32'h314ff108;
		S_AXI_ARESETN = 1'b0;
		{awvalid, wvalid, bready, arvalid, rready, break_req} = '0;
		{awaddr, araddr, wstrb, stall_len, wdata} = '0;
		{rd_chk, halt_chk, exp_halt, step_chk, cc_chk} = '0;
		rd_mask = '0;
		rd_exp = '0;
		halt_word = 32'd1 << dbg_pkg::HALT_BIT;
		repeat (16) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		@(negedge S_AXI_ACLK);

		// Status inside the reset hold window
		read_status_expect(32'd1 << dbg_pkg::RESET_BIT, 32'd1 << dbg_pkg::RESET_BIT);
		while (cpu_reset) @(negedge S_AXI_ACLK);

		// Register write and readback
		write_reg(5'd3, $random(seed), 1'b0);
		write_reg(5'd28, $random(seed), 1'b0);
		read_reg_expect(5'd3, 1'b0);
		read_reg_expect(5'd28, 1'b0);

		// Halt from the register writes released, then set again
		exp_halt = 1'b0;
		halt_chk = 1'b1;
		send_command('0, 1'b1);
		halt_chk = 1'b0;
		read_status_expect(halt_word, '0);
		exp_halt = 1'b1;
		halt_chk = 1'b1;
		send_command(halt_word, 1'b0);
		halt_chk = 1'b0;
		read_status_expect(halt_word, halt_word);

		// Step and clear-cache from halt
		step_chk = 1'b1;
		send_command(32'd1 << dbg_pkg::STEP_BIT, 1'b1);
		step_chk = 1'b0;
		cc_chk = 1'b1;
		send_command((32'd1 << dbg_pkg::CLEAR_CACHE_BIT) | halt_word, 1'b1);
		cc_chk = 1'b0;

		// Break pulse
		break_req = 1'b1;
		@(negedge S_AXI_ACLK);
		break_req = 1'b0;
		repeat (4) @(negedge S_AXI_ACLK);

		// Backpressure on B and R
		for (int i = 0; i < 8; i++)
		begin
			idx = 5'($random(seed));
			write_reg(idx, $random(seed), 1'b1);
			read_reg_expect(idx, 1'b1);
		end
		repeat (4) @(negedge S_AXI_ACLK);

		$display("Summary: %0d writes, %0d reads, %0d errors",
			writes_done, reads_done, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Run limit
	initial
	begin
		while (cycle_count < CYCLE_LIMIT)
		begin
			@(posedge S_AXI_ACLK);
			cycle_count = cycle_count + 1;
		end
		$display("Timeout after %0d cycles, a bus transaction never completed", CYCLE_LIMIT);
		$display("Summary: %0d writes, %0d reads, %0d errors",
			writes_done, reads_done, errors);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
logic/dbg_pkg.sv
logic/dbg_skid.sv
logic/dbg_write_path.sv
logic/dbg_read_path.sv
logic/cpu_run_control.sv
logic/cpu_debug_port.sv
sim/tb_cpu_stub.sv
sim/tb_cpu_debug_port.sv
